// File: src/switch_pkg.sv
/*
  Data word format for the two-class switch.
  Class bit layout, the two views of a word and FIFO sizing.
*/
`default_nettype none

package switch_pkg;

  //////////////////////////////////////////////////
  // Word layout
  //////////////////////////////////////////////////
  localparam int word_w    = 10;
  localparam int payload_w = 9;

  // Class FIFO sizing
  localparam int fifo_depth = 8;
  localparam int ptr_w      = $clog2(fifo_depth);
  localparam int count_w    = $clog2(fifo_depth + 1);

  // Class bit sits on top of the payload
  typedef struct packed {
    logic                 cls;
    logic [payload_w-1:0] payload;
  } class_word_t;

  // Raw word on the wires, decoded view in the demux
  typedef union packed {
    logic [word_w-1:0] raw;
    class_word_t       fields;
  } class_word_u;

  // One-cycle drop report
  typedef struct packed {
    logic strobe;
    logic cls;
  } drop_t;

endpackage

`default_nettype wire

// File: src/cfg_pkg.sv
/*
  Register map of the switch configuration block.
  Addresses, widths and the control bundle to the datapath.
*/
`default_nettype none

package cfg_pkg;

  // Register bus widths
  localparam int addr_w = 3;
  localparam int reg_w  = 8;

  //////////////////////////////////////////////////
  // Register addresses
  //////////////////////////////////////////////////
  localparam logic [addr_w-1:0] addr_thr0   = 3'd0;
  localparam logic [addr_w-1:0] addr_thr1   = 3'd1;
  localparam logic [addr_w-1:0] addr_drop0  = 3'd2;
  localparam logic [addr_w-1:0] addr_drop1  = 3'd3;
  localparam logic [addr_w-1:0] addr_status = 3'd4;

  // Almost-full level after reset
  localparam logic [switch_pkg::count_w-1:0] thr_reset = 4'd6;

  // Drop counters stop here
  localparam logic [reg_w-1:0] drop_max = 8'd255;

  // Thresholds handed to the FIFOs
  typedef struct packed {
    logic [switch_pkg::count_w-1:0] thr1;
    logic [switch_pkg::count_w-1:0] thr0;
  } switch_ctrl_t;

endpackage

`default_nettype wire

// File: src/class_demux.sv
/*
  Class demultiplexer.
  Registers each offered word and steers it to the FIFO of its class,
  or drops it and reports the drop when that FIFO is almost full.
*/
`timescale 1ns/10ps
`default_nettype none

module class_demux (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    in_valid,
  input  wire switch_pkg::class_word_u in_word,
  input  wire logic                    af0,
  input  wire logic                    af1,
  output logic                         push0,
  output logic                         push1,
  output switch_pkg::class_word_u      push_word,
  output switch_pkg::drop_t            drop
);

  import switch_pkg::*;

  logic        valid_q;
  class_word_u word_q;
  logic        word_cls;
  logic        cls_af;

  //////////////////////////////////////////////////
  // Input stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      word_q <= in_word;
    end
  end

  //////////////////////////////////////////////////
  // Routing
  //////////////////////////////////////////////////

  // Class read through the decoded view
  assign word_cls = word_q.fields.cls;

  // Almost-full of the target FIFO
  assign cls_af = word_cls ? af1 : af0;

  always_comb begin
    push0 = valid_q && !word_cls && !cls_af;
    push1 = valid_q && word_cls && !cls_af;
  end

  // Same word goes to both FIFOs, push strobes pick one
  assign push_word = word_q;

  // Held-off word is reported and lost
  always_comb begin
    drop.strobe = valid_q && cls_af;
    drop.cls    = word_cls;
  end

endmodule

`default_nettype wire

// File: src/class_fifo.sv
/*
  First-word-fall-through class FIFO.
  Head word is always visible, almost-full compares the fill count
  against a programmable threshold, an empty pop flags an error pulse.
*/
`timescale 1ns/10ps
`default_nettype none

module class_fifo (
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  input  wire logic                        push,
  input  wire logic [switch_pkg::word_w-1:0]  push_word,
  input  wire logic                        pop,
  input  wire logic [switch_pkg::count_w-1:0] threshold,
  output logic [switch_pkg::word_w-1:0]       head_word,
  output logic                             empty,
  output logic                             almost_full,
  output logic                             err
);

  import switch_pkg::*;

  logic [word_w-1:0]  mem [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] fill_count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  // Next slot in the ring
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] result;
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      result = '0;
    end else begin
      result = ptr + 1'b1;
    end
    return result;
  endfunction

  //////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////
  assign empty = (fill_count == '0);
  assign full  = (fill_count == count_w'(fifo_depth));

  // Back-pressure level for the demux
  assign almost_full = (fill_count >= threshold);

  // Accepted operations
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // Head falls through to the output
  assign head_word = mem[rd_ptr];

  //////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10: begin
          fill_count <= fill_count + 1'b1;
        end
        2'b01: begin
          fill_count <= fill_count - 1'b1;
        end
        default: begin
          // Push with pop, count unchanged
          fill_count <= fill_count;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Underflow
  //////////////////////////////////////////////////

  // One-cycle pulse for a pop that found nothing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err <= 1'b0;
    end else begin
      err <= pop && empty;
    end
  end

endmodule

`default_nettype wire

// File: src/switch_cfg_regs.sv
/*
  Switch configuration registers.
  Clamped almost-full thresholds, saturating drop counters per class,
  a sticky error bit and the combinational read decode.
*/
`timescale 1ns/10ps
`default_nettype none

module switch_cfg_regs (
  input  wire logic                       clk,
  input  wire logic                       arst_n,
  input  wire logic                       cfg_wr,
  input  wire logic [cfg_pkg::addr_w-1:0] cfg_addr,
  input  wire logic [cfg_pkg::reg_w-1:0]  cfg_wdata,
  input  wire switch_pkg::drop_t          drop,
  input  wire logic                       err0,
  input  wire logic                       err1,
  output cfg_pkg::switch_ctrl_t           ctrl,
  output logic                            error,
  output logic [cfg_pkg::reg_w-1:0]       cfg_rdata
);

  import switch_pkg::*;
  import cfg_pkg::*;

  logic [count_w-1:0] thr0;
  logic [count_w-1:0] thr1;
  logic [reg_w-1:0]   drop0;
  logic [reg_w-1:0]   drop1;
  logic               status_wr;

  // Threshold kept within 1 .. fifo_depth
  function automatic logic [count_w-1:0] clamp_thr(input logic [reg_w-1:0] value);
    logic [count_w-1:0] result;
    if (value > reg_w'(fifo_depth)) begin
      result = count_w'(fifo_depth);
    end else if (value == '0) begin
      result = count_w'(1);
    end else begin
      result = value[count_w-1:0];
    end
    return result;
  endfunction

  function automatic logic [reg_w-1:0] sat_inc(input logic [reg_w-1:0] value);
    return (value == drop_max) ? value : value + 1'b1;
  endfunction

  assign status_wr = cfg_wr && (cfg_addr == addr_status);

  //////////////////////////////////////////////////
  // Thresholds
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thr0 <= thr_reset;
      thr1 <= thr_reset;
    end else if (cfg_wr) begin
      if (cfg_addr == addr_thr0) begin
        thr0 <= clamp_thr(cfg_wdata);
      end
      if (cfg_addr == addr_thr1) begin
        thr1 <= clamp_thr(cfg_wdata);
      end
    end
  end

  always_comb begin
    ctrl.thr0 = thr0;
    ctrl.thr1 = thr1;
  end

  // Drop counters and sticky error
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      drop0 <= '0;
      drop1 <= '0;
      error <= 1'b0;
    end else begin
      if (drop.strobe && !drop.cls) begin
        drop0 <= sat_inc(drop0);
      end
      if (drop.strobe && drop.cls) begin
        drop1 <= sat_inc(drop1);
      end
      // New underflow wins over a clear
      if (err0 || err1) begin
        error <= 1'b1;
      end else if (status_wr) begin
        error <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////
  always_comb begin
    case (cfg_addr)
      addr_thr0:   cfg_rdata = reg_w'(thr0);
      addr_thr1:   cfg_rdata = reg_w'(thr1);
      addr_drop0:  cfg_rdata = drop0;
      addr_drop1:  cfg_rdata = drop1;
      addr_status: cfg_rdata = reg_w'(error);
      default:     cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/class_switch.sv
/*
  Two-class switching layer, top level.
  Demux feeds one FWFT FIFO per class; a register block sets
  the thresholds, counts drops and holds the error flag.
*/
`timescale 1ns/10ps
`default_nettype none

module class_switch (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire logic                          in_valid,
  input  wire logic [switch_pkg::word_w-1:0] in_word,
  input  wire logic                          pop0,
  input  wire logic                          pop1,
  input  wire logic                          cfg_wr,
  input  wire logic [cfg_pkg::addr_w-1:0]    cfg_addr,
  input  wire logic [cfg_pkg::reg_w-1:0]     cfg_wdata,
  output logic [switch_pkg::word_w-1:0]      out0,
  output logic [switch_pkg::word_w-1:0]      out1,
  output logic                               empty0,
  output logic                               empty1,
  output logic                               error,
  output logic [cfg_pkg::reg_w-1:0]          cfg_rdata
);

  import switch_pkg::*;
  import cfg_pkg::*;

  logic         push0;
  logic         push1;
  class_word_u  push_word;
  drop_t        drop;
  logic         af0;
  logic         af1;
  logic         err0;
  logic         err1;
  switch_ctrl_t ctrl;

  //////////////////////////////////////////////////
  // Register block
  //////////////////////////////////////////////////
  switch_cfg_regs i_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .drop      (drop),
    .err0      (err0),
    .err1      (err1),
    .ctrl      (ctrl),
    .error     (error),
    .cfg_rdata (cfg_rdata)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  class_demux i_demux (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .af0       (af0),
    .af1       (af1),
    .push0     (push0),
    .push1     (push1),
    .push_word (push_word),
    .drop      (drop)
  );

  // Class 0
  class_fifo i_fifo0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (push0),
    .push_word   (push_word.raw),
    .pop         (pop0),
    .threshold   (ctrl.thr0),
    .head_word   (out0),
    .empty       (empty0),
    .almost_full (af0),
    .err         (err0)
  );

  // Class 1
  class_fifo i_fifo1 (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (push1),
    .push_word   (push_word.raw),
    .pop         (pop1),
    .threshold   (ctrl.thr1),
    .head_word   (out1),
    .empty       (empty1),
    .almost_full (af1),
    .err         (err1)
  );

endmodule

`default_nettype wire

// File: bench/class_switch_assertions.sv
/*
  Bound checks on the two-class switch top level.
  Push exclusivity, empty flag against fill count, sticky error.
*/
`timescale 1ns/10ps
`default_nettype none

module class_switch_assertions (
  input wire logic                       clk,
  input wire logic                       arst_n,
  input wire logic                       push0,
  input wire logic                       push1,
  input wire logic                       pop0,
  input wire logic                       pop1,
  input wire logic                       empty0,
  input wire logic                       empty1,
  input wire logic                       error,
  input wire logic                       cfg_wr,
  input wire logic [cfg_pkg::addr_w-1:0] cfg_addr
);

  import switch_pkg::*;
  import cfg_pkg::*;

  logic [count_w-1:0] fill0;
  logic [count_w-1:0] fill1;
  int                 failures = 0;

  // Fill counts rebuilt from the push and pop strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill0 <= '0;
      fill1 <= '0;
    end else begin
      fill0 <= fill0 + count_w'(push0) - count_w'(pop0 && (fill0 != '0));
      fill1 <= fill1 + count_w'(push1) - count_w'(pop1 && (fill1 != '0));
    end
  end

  // A word goes to one class only
  a_one_push : assert property (@(posedge clk) disable iff (!arst_n)
    !(push0 && push1))
    else begin
      $error("push0 and push1 high together");
      failures++;
    end

  a_empty0 : assert property (@(posedge clk) disable iff (!arst_n)
    (fill0 == '0) |-> empty0)
    else begin
      $error("empty0 low with fill count 0");
      failures++;
    end

  a_empty1 : assert property (@(posedge clk) disable iff (!arst_n)
    (fill1 == '0) |-> empty1)
    else begin
      $error("empty1 low with fill count 0");
      failures++;
    end

  // Only a status write clears the error bit
  a_error_sticky : assert property (@(posedge clk) disable iff (!arst_n)
    $fell(error) |-> $past(cfg_wr && (cfg_addr == addr_status)))
    else begin
      $error("error fell without a status write");
      failures++;
    end

endmodule

`default_nettype wire

// File: bench/class_switch_tb.sv
/*
  Testbench for the two-class switch.
  Directed and random traffic against a queue-based reference model.
*/
`timescale 1ns/10ps
`default_nettype none

module class_switch_tb;

  import switch_pkg::*;
  import cfg_pkg::*;

  localparam int cycle_limit = 3000;

  logic               clk;
  logic               arst_n;
  logic               in_valid;
  logic [word_w-1:0]  in_word;
  logic               pop0;
  logic               pop1;
  logic               cfg_wr;
  logic [addr_w-1:0]  cfg_addr;
  logic [reg_w-1:0]   cfg_wdata;
  logic [word_w-1:0]  out0;
  logic [word_w-1:0]  out1;
  logic               empty0;
  logic               empty1;
  logic               error;
  logic [reg_w-1:0]   cfg_rdata;

  // Reference model state
  logic [word_w-1:0]  exp_q0[$];
  logic [word_w-1:0]  exp_q1[$];
  logic               exp_valid_q;
  logic [word_w-1:0]  exp_word_q;
  logic [count_w-1:0] exp_thr0;
  logic [count_w-1:0] exp_thr1;
  logic [reg_w-1:0]   exp_drop0;
  logic [reg_w-1:0]   exp_drop1;
  logic               exp_error;
  logic               exp_err_q;

  int errors;
  int checks;
  int cycles;

  class_switch i_class_switch (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .pop0      (pop0),
    .pop1      (pop1),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .out0      (out0),
    .out1      (out1),
    .empty0    (empty0),
    .empty1    (empty1),
    .error     (error),
    .cfg_rdata (cfg_rdata)
  );

  bind class_switch class_switch_assertions i_assertions (
    .clk      (clk),
    .arst_n   (arst_n),
    .push0    (push0),
    .push1    (push1),
    .pop0     (pop0),
    .pop1     (pop1),
    .empty0   (empty0),
    .empty1   (empty1),
    .error    (error),
    .cfg_wr   (cfg_wr),
    .cfg_addr (cfg_addr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////
  function automatic logic [count_w-1:0] limit_threshold(input logic [reg_w-1:0] d);
    if (d == 0) return 1;
    if (d > fifo_depth) return fifo_depth;
    return d[count_w-1:0];
  endfunction

  // One clock edge applied to the state before the edge
  function void predict_edge(input logic v, input logic [word_w-1:0] w, input logic p0,
                             input logic p1, input logic wr, input logic [addr_w-1:0] a,
                             input logic [reg_w-1:0] d);
    logic af0;
    logic af1;
    logic was_empty0;
    logic was_empty1;
    af0 = exp_q0.size() >= exp_thr0;
    af1 = exp_q1.size() >= exp_thr1;
    was_empty0 = exp_q0.size() == 0;
    was_empty1 = exp_q1.size() == 0;
    // Underflow pulse lands in the sticky bit one edge later
    if (exp_err_q) exp_error = 1'b1;
    else if (wr && a == addr_status) exp_error = 1'b0;
    exp_err_q = (p0 && was_empty0) || (p1 && was_empty1);
    if (p0 && !was_empty0) void'(exp_q0.pop_front());
    if (p1 && !was_empty1) void'(exp_q1.pop_front());
    if (exp_valid_q) begin
      if (exp_word_q[word_w-1]) begin
        if (af1) exp_drop1 = (exp_drop1 == 8'hff) ? exp_drop1 : exp_drop1 + 1;
        else exp_q1.push_back(exp_word_q);
      end else begin
        if (af0) exp_drop0 = (exp_drop0 == 8'hff) ? exp_drop0 : exp_drop0 + 1;
        else exp_q0.push_back(exp_word_q);
      end
    end
    if (wr && a == addr_thr0) exp_thr0 = limit_threshold(d);
    if (wr && a == addr_thr1) exp_thr1 = limit_threshold(d);
    exp_valid_q = v;
    if (v) exp_word_q = w;
  endfunction

  function automatic logic [reg_w-1:0] expected_rdata(input logic [addr_w-1:0] a);
    case (a)
      3'd0:    return reg_w'(exp_thr0);
      3'd1:    return reg_w'(exp_thr1);
      3'd2:    return exp_drop0;
      3'd3:    return exp_drop1;
      3'd4:    return reg_w'(exp_error);
      default: return '0;
    endcase
  endfunction

  always @(posedge clk) begin
    if (!arst_n) begin
      exp_q0.delete();
      exp_q1.delete();
      exp_valid_q = 1'b0;
      exp_thr0 = 6;
      exp_thr1 = 6;
      exp_drop0 = '0;
      exp_drop1 = '0;
      exp_error = 1'b0;
      exp_err_q = 1'b0;
    end else begin
      predict_edge(in_valid, in_word, pop0, pop1, cfg_wr, cfg_addr, cfg_wdata);
    end
  end

  // Comparison on the falling edge where outputs have settled
  always @(negedge clk) begin
    checks++;
    assert (empty0 == (exp_q0.size() == 0)) else begin
      errors++;
      $display("FAIL %0t: empty0 is %b, model fill %0d", $time, empty0, exp_q0.size());
    end
    assert (empty1 == (exp_q1.size() == 0)) else begin
      errors++;
      $display("FAIL %0t: empty1 is %b, model fill %0d", $time, empty1, exp_q1.size());
    end
    if (exp_q0.size() != 0) begin
      assert (out0 == exp_q0[0]) else begin
        errors++;
        $display("FAIL %0t: out0 is %h, expected %h", $time, out0, exp_q0[0]);
      end
    end
    if (exp_q1.size() != 0) begin
      assert (out1 == exp_q1[0]) else begin
        errors++;
        $display("FAIL %0t: out1 is %h, expected %h", $time, out1, exp_q1[0]);
      end
    end
    assert (error == exp_error) else begin
      errors++;
      $display("FAIL %0t: error is %b, expected %b", $time, error, exp_error);
    end
    assert (cfg_rdata == expected_rdata(cfg_addr)) else begin
      errors++;
      $display("FAIL %0t: register %0d reads %h, expected %h", $time, cfg_addr, cfg_rdata,
               expected_rdata(cfg_addr));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////
  task automatic step(input logic v, input logic [word_w-1:0] w, input logic p0, input logic p1);
    @(posedge clk);
    in_valid <= v;
    in_word  <= w;
    pop0     <= p0;
    pop1     <= p1;
    cfg_wr   <= 1'b0;
  endtask

  task automatic write_reg(input logic [addr_w-1:0] a, input logic [reg_w-1:0] d);
    @(posedge clk);
    in_valid  <= 1'b0;
    pop0      <= 1'b0;
    pop1      <= 1'b0;
    cfg_wr    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
  endtask

  // Direct readback against a value fixed by the register rules
  task automatic expect_reg(input logic [addr_w-1:0] a, input logic [reg_w-1:0] expected);
    step(1'b0, '0, 1'b0, 1'b0);
    cfg_addr <= a;
    @(negedge clk);
    checks++;
    assert (cfg_rdata == expected) else begin
      errors++;
      $display("FAIL %0t: readback of %0d is %h, expected %h", $time, a, cfg_rdata, expected);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    cycles = 0;
    void'($urandom(32));
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_word   = '0;
    pop0      = 1'b0;
    pop1      = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // Threshold reset values and clamping
    expect_reg(addr_thr0, 8'd6);
    expect_reg(addr_thr1, 8'd6);
    write_reg(addr_thr0, 8'd12);
    expect_reg(addr_thr0, 8'd8);
    write_reg(addr_thr1, 8'd0);
    expect_reg(addr_thr1, 8'd1);
    write_reg(addr_thr0, 8'd6);
    write_reg(addr_thr1, 8'd6);

    // Steering by class and order per class
    for (int i = 0; i < 6; i++) begin
      step(1'b1, {i[0], 9'(i * 37 + 5)}, 1'b0, 1'b0);
    end
    repeat (2) step(1'b0, '0, 1'b0, 1'b0);
    repeat (3) step(1'b0, '0, 1'b1, 1'b1);

    // Back-pressure on class 0
    write_reg(addr_thr0, 8'd3);
    for (int i = 0; i < 6; i++) begin
      step(1'b1, {1'b0, 9'(i + 9'h40)}, 1'b0, 1'b0);
    end
    repeat (2) step(1'b0, '0, 1'b0, 1'b0);
    expect_reg(addr_drop0, 8'd3);
    repeat (3) step(1'b0, '0, 1'b1, 1'b0);

    // Underflow sets the sticky error while the class 1 word stays put
    step(1'b1, {1'b1, 9'h0aa}, 1'b0, 1'b0);
    repeat (2) step(1'b0, '0, 1'b0, 1'b0);
    step(1'b0, '0, 1'b1, 1'b0);
    repeat (3) step(1'b0, '0, 1'b0, 1'b0);
    expect_reg(addr_status, 8'd1);
    write_reg(addr_status, 8'd0);
    expect_reg(addr_status, 8'd0);
    step(1'b0, '0, 1'b0, 1'b1);
    write_reg(addr_thr0, 8'd6);

    // Random traffic
    for (int i = 0; i < 1000; i++) begin
      @(posedge clk);
      in_valid  <= $urandom_range(0, 1);
      in_word   <= $urandom_range(0, 1023);
      pop0      <= ($urandom_range(0, 9) < 4);
      pop1      <= ($urandom_range(0, 9) < 4);
      cfg_wr    <= ($urandom_range(0, 7) == 0);
      cfg_addr  <= $urandom_range(0, 7);
      cfg_wdata <= $urandom_range(0, 15);
    end
    repeat (4) step(1'b0, '0, 1'b0, 1'b0);

    // Bound assertion failures count as errors too
    errors += i_class_switch.i_assertions.failures;

    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/switch_pkg.sv
src/cfg_pkg.sv
src/class_demux.sv
src/class_fifo.sv
src/switch_cfg_regs.sv
src/class_switch.sv
bench/class_switch_assertions.sv
bench/class_switch_tb.sv
